// File: Bender.yml
package:
  name: mem_pipe

sources:
  - logic/mem_pipe_pkg.sv
  - logic/data_sram.sv
  - logic/ex_stage.sv
  - logic/mem_stage.sv
  - logic/wb_stage.sv
  - logic/mem_pipe_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_checker.sv
      - tb/mem_pipe_assertions.sv
      - tb/tb_mem_pipe.sv

// File: logic/data_sram.sv
module data_sram (
    input  logic                    clk,
    input  mem_pipe_pkg::sram_req_t sram_req,
    output mem_pipe_pkg::word_t     rdata
);

    localparam int DEPTH = 1 << mem_pipe_pkg::SRAM_DEPTH_LOG2;

    mem_pipe_pkg::word_t                      mem [DEPTH];
    logic [mem_pipe_pkg::SRAM_DEPTH_LOG2-1:0] word_idx;

    // word index sits above the byte offset
    assign word_idx = sram_req.addr[mem_pipe_pkg::BYTE_OFFSET_BITS +: mem_pipe_pkg::SRAM_DEPTH_LOG2];

    always_ff @(posedge clk) begin
        if (sram_req.en && sram_req.we) begin
            for (int i = 0; i < $bits(mem_pipe_pkg::strb_t); i++) begin
                if (sram_req.wstrb[i]) begin
                    mem[word_idx][8*i +: 8] <= sram_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // read register holds until the next enabled read
    always_ff @(posedge clk) begin
        if (sram_req.en && !sram_req.we) begin
            rdata <= mem[word_idx];
        end
    end

endmodule

// File: logic/ex_stage.sv
module ex_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    in_valid,
    input  mem_pipe_pkg::issue_t    in_instr,
    input  logic                    ms_allowin,
    input  logic                    wb_ex,
    output logic                    in_allowin,
    output logic                    es2ms_valid,
    output mem_pipe_pkg::es2ms_t    es2ms,
    output mem_pipe_pkg::sram_req_t sram_req
);

    logic                 es_valid;
    mem_pipe_pkg::issue_t es_instr;
    mem_pipe_pkg::word_t  eff_addr;
    logic                 is_load;
    logic                 is_store;
    logic                 misaligned;
    mem_pipe_pkg::strb_t  st_strb;
    mem_pipe_pkg::word_t  st_lanes;

    // no new instruction while the flush edge is pending
    assign in_allowin  = (~es_valid | ms_allowin) & ~wb_ex;
    assign es2ms_valid = es_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (wb_ex) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_instr <= in_instr;
        end
    end

    assign eff_addr = es_instr.base + es_instr.offset;

    // access class, alignment and store lanes
    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        misaligned = 1'b0;
        st_strb    = '0;
        st_lanes   = es_instr.st_data;
        case (es_instr.op)
            mem_pipe_pkg::OP_LD_B, mem_pipe_pkg::OP_LD_BU: begin
                is_load = 1'b1;
            end
            mem_pipe_pkg::OP_LD_H, mem_pipe_pkg::OP_LD_HU: begin
                is_load    = 1'b1;
                misaligned = eff_addr[0];
            end
            mem_pipe_pkg::OP_LD_W: begin
                is_load    = 1'b1;
                misaligned = |eff_addr[1:0];
            end
            mem_pipe_pkg::OP_ST_B: begin
                is_store = 1'b1;
                st_strb  = 4'b0001 << eff_addr[1:0];
                st_lanes = {4{es_instr.st_data[7:0]}};
            end
            mem_pipe_pkg::OP_ST_H: begin
                is_store   = 1'b1;
                misaligned = eff_addr[0];
                st_strb    = eff_addr[1] ? 4'b1100 : 4'b0011;
                st_lanes   = {2{es_instr.st_data[15:0]}};
            end
            mem_pipe_pkg::OP_ST_W: begin
                is_store   = 1'b1;
                misaligned = |eff_addr[1:0];
                st_strb    = 4'b1111;
            end
            default: begin
            end
        endcase
    end

    assign es2ms.pc     = es_instr.pc;
    assign es2ms.op     = es_instr.op;
    assign es2ms.rd     = es_instr.rd;
    // loads and ALU ops write rd
    assign es2ms.rf_we  = ~is_store;
    assign es2ms.result = eff_addr;
    assign es2ms.exc    = misaligned ? mem_pipe_pkg::EXC_ALE : mem_pipe_pkg::EXC_NONE;

    // request only on the transfer edge, never for a faulting or flushed access
    assign sram_req.en    = es_valid & ms_allowin & ~wb_ex & (is_load | is_store) & ~misaligned;
    assign sram_req.we    = is_store;
    assign sram_req.wstrb = st_strb;
    assign sram_req.addr  = eff_addr;
    assign sram_req.wdata = st_lanes;

endmodule

// File: logic/mem_pipe_pkg.sv
package mem_pipe_pkg;

    // word address bits decoded by the data SRAM
    localparam int SRAM_DEPTH_LOG2 = 8;
    // byte offset bits below the word address
    localparam int BYTE_OFFSET_BITS = 2;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    // one strobe bit per byte lane
    typedef logic [(1 << BYTE_OFFSET_BITS)-1:0] strb_t;

    typedef enum logic [3:0] {
        OP_ALU,
        OP_LD_B,
        OP_LD_H,
        OP_LD_W,
        OP_LD_BU,
        OP_LD_HU,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W
    } mem_op_e;

    typedef enum logic {
        EXC_NONE,
        EXC_ALE
    } exc_e;

    typedef struct packed {
        word_t     pc;
        mem_op_e   op;
        word_t     base;
        word_t     offset;
        word_t     st_data;
        reg_addr_t rd;
    } issue_t;

    // result is the effective address for memory ops, the sum for ALU ops
    typedef struct packed {
        word_t     pc;
        mem_op_e   op;
        reg_addr_t rd;
        logic      rf_we;
        word_t     result;
        exc_e      exc;
    } es2ms_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      rf_we;
        word_t     wdata;
        exc_e      exc;
        word_t     badv;
    } ms2ws_t;

    typedef struct packed {
        logic  en;
        logic  we;
        strb_t wstrb;
        word_t addr;
        word_t wdata;
    } sram_req_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        exc_e  code;
        word_t badv;
    } exc_report_t;

endpackage

// File: logic/mem_pipe_top.sv
module mem_pipe_top (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      in_valid,
    input  mem_pipe_pkg::issue_t      in_instr,
    input  logic                      retire_ready,
    output logic                      in_allowin,
    output mem_pipe_pkg::rf_write_t   rf_wr,
    output mem_pipe_pkg::exc_report_t exc
);

    logic                    es2ms_valid;
    mem_pipe_pkg::es2ms_t    es2ms;
    logic                    ms_allowin;
    logic                    ms2ws_valid;
    mem_pipe_pkg::ms2ws_t    ms2ws;
    logic                    ws_allowin;
    logic                    wb_ex;
    mem_pipe_pkg::sram_req_t sram_req;
    mem_pipe_pkg::word_t     rdata;

    ex_stage u_ex_stage (
        .clk         (clk),
        .resetn      (resetn),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .ms_allowin  (ms_allowin),
        .wb_ex       (wb_ex),
        .in_allowin  (in_allowin),
        .es2ms_valid (es2ms_valid),
        .es2ms       (es2ms),
        .sram_req    (sram_req)
    );

    mem_stage u_mem_stage (
        .clk         (clk),
        .resetn      (resetn),
        .es2ms_valid (es2ms_valid),
        .es2ms       (es2ms),
        .ws_allowin  (ws_allowin),
        .wb_ex       (wb_ex),
        .rdata       (rdata),
        .ms_allowin  (ms_allowin),
        .ms2ws_valid (ms2ws_valid),
        .ms2ws       (ms2ws)
    );

    wb_stage u_wb_stage (
        .clk          (clk),
        .resetn       (resetn),
        .ms2ws_valid  (ms2ws_valid),
        .ms2ws        (ms2ws),
        .retire_ready (retire_ready),
        .ws_allowin   (ws_allowin),
        .wb_ex        (wb_ex),
        .rf_wr        (rf_wr),
        .exc          (exc)
    );

    data_sram u_data_sram (
        .clk      (clk),
        .sram_req (sram_req),
        .rdata    (rdata)
    );

endmodule

// File: logic/mem_stage.sv
module mem_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 es2ms_valid,
    input  mem_pipe_pkg::es2ms_t es2ms,
    input  logic                 ws_allowin,
    input  logic                 wb_ex,
    input  mem_pipe_pkg::word_t  rdata,
    output logic                 ms_allowin,
    output logic                 ms2ws_valid,
    output mem_pipe_pkg::ms2ws_t ms2ws
);

    logic                 ms_valid;
    mem_pipe_pkg::es2ms_t ms_instr;
    logic [7:0]           ld_byte;
    logic [15:0]          ld_half;
    mem_pipe_pkg::word_t  ld_value;

    assign ms_allowin  = ~ms_valid | ws_allowin;
    assign ms2ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
        end else if (wb_ex) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es2ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es2ms_valid && ms_allowin) begin
            ms_instr <= es2ms;
        end
    end

    // lane select from the low address bits
    always_comb begin
        case (ms_instr.result[1:0])
            2'b00:   ld_byte = rdata[7:0];
            2'b01:   ld_byte = rdata[15:8];
            2'b10:   ld_byte = rdata[23:16];
            default: ld_byte = rdata[31:24];
        endcase
    end

    assign ld_half = ms_instr.result[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (ms_instr.op)
            mem_pipe_pkg::OP_LD_B:  ld_value = {{24{ld_byte[7]}}, ld_byte};
            mem_pipe_pkg::OP_LD_BU: ld_value = {24'b0, ld_byte};
            mem_pipe_pkg::OP_LD_H:  ld_value = {{16{ld_half[15]}}, ld_half};
            mem_pipe_pkg::OP_LD_HU: ld_value = {16'b0, ld_half};
            mem_pipe_pkg::OP_LD_W:  ld_value = rdata;
            // ALU result passes through, stores write nothing
            default:                ld_value = ms_instr.result;
        endcase
    end

    assign ms2ws.pc    = ms_instr.pc;
    assign ms2ws.rd    = ms_instr.rd;
    assign ms2ws.rf_we = ms_instr.rf_we;
    assign ms2ws.wdata = ld_value;
    assign ms2ws.exc   = ms_instr.exc;
    assign ms2ws.badv  = ms_instr.result;

endmodule

// File: logic/wb_stage.sv
module wb_stage (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      ms2ws_valid,
    input  mem_pipe_pkg::ms2ws_t      ms2ws,
    input  logic                      retire_ready,
    output logic                      ws_allowin,
    output logic                      wb_ex,
    output mem_pipe_pkg::rf_write_t   rf_wr,
    output mem_pipe_pkg::exc_report_t exc
);

    logic                 ws_valid;
    mem_pipe_pkg::ms2ws_t ws_instr;
    logic                 retire;
    logic                 has_exc;

    assign retire     = ws_valid & retire_ready;
    assign has_exc    = (ws_instr.exc != mem_pipe_pkg::EXC_NONE);
    assign ws_allowin = ~ws_valid | retire_ready;

    // faulting instruction retires as a flush
    assign wb_ex = retire & has_exc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else if (wb_ex) begin
            // the memory stage content is younger, drop it
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms2ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms2ws_valid && ws_allowin) begin
            ws_instr <= ms2ws;
        end
    end

    assign rf_wr.we    = retire & ws_instr.rf_we & ~has_exc;
    assign rf_wr.waddr = ws_instr.rd;
    assign rf_wr.wdata = ws_instr.wdata;

    assign exc.valid = wb_ex;
    assign exc.pc    = ws_instr.pc;
    assign exc.code  = ws_instr.exc;
    assign exc.badv  = ws_instr.badv;

endmodule

// File: sources.f
logic/mem_pipe_pkg.sv
logic/data_sram.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/mem_pipe_top.sv
tb/tb_clock_gen.sv
tb/tb_checker.sv
tb/mem_pipe_assertions.sv
tb/tb_mem_pipe.sv

// File: tb/mem_pipe_assertions.sv
module mem_pipe_assertions (
    input logic                      clk,
    input logic                      resetn,
    input logic                      in_allowin,
    input logic                      wb_ex,
    input mem_pipe_pkg::rf_write_t   rf_wr,
    input mem_pipe_pkg::exc_report_t exc,
    input mem_pipe_pkg::sram_req_t   sram_req
);

    int violations = 0;

    // a retiring instruction either writes rd or traps
    write_xor_exc: assert property (@(posedge clk) disable iff (!resetn)
        !(rf_wr.we && exc.valid))
        else begin
            $error("register write and exception report in the same cycle");
            violations++;
        end

    no_sram_on_flush: assert property (@(posedge clk) disable iff (!resetn)
        wb_ex |-> !sram_req.en)
        else begin
            $error("SRAM request issued during an exception flush");
            violations++;
        end

    no_accept_on_flush: assert property (@(posedge clk) disable iff (!resetn)
        wb_ex |-> !in_allowin)
        else begin
            $error("in_allowin high during an exception flush");
            violations++;
        end

endmodule

bind mem_pipe_top mem_pipe_assertions u_assertions (
    .clk        (clk),
    .resetn     (resetn),
    .in_allowin (in_allowin),
    .wb_ex      (wb_ex),
    .rf_wr      (rf_wr),
    .exc        (exc),
    .sram_req   (sram_req)
);

// File: tb/tb_checker.sv
module tb_checker (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      in_valid,
    input  logic                      in_allowin,
    input  mem_pipe_pkg::issue_t      in_instr,
    input  mem_pipe_pkg::rf_write_t   rf_wr,
    input  mem_pipe_pkg::exc_report_t exc,
    output int                        pass_count,
    output int                        fail_count,
    output int                        outstanding
);

    typedef enum logic [1:0] {K_WRITE, K_EXC, K_STORE} outcome_e;

    // value is wdata for a write, badv for an exception
    typedef struct packed {
        logic [15:0]             idx;
        outcome_e                kind;
        mem_pipe_pkg::word_t     pc;
        mem_pipe_pkg::reg_addr_t rd;
        mem_pipe_pkg::word_t     value;
    } expect_t;

    expect_t             pending_q[$];
    mem_pipe_pkg::word_t model_mem [1 << mem_pipe_pkg::SRAM_DEPTH_LOG2];
    int                  accepted = 0;

    function automatic int access_size(mem_pipe_pkg::mem_op_e op);
        case (op)
            mem_pipe_pkg::OP_LD_B, mem_pipe_pkg::OP_LD_BU, mem_pipe_pkg::OP_ST_B: return 1;
            mem_pipe_pkg::OP_LD_H, mem_pipe_pkg::OP_LD_HU, mem_pipe_pkg::OP_ST_H: return 2;
            mem_pipe_pkg::OP_LD_W, mem_pipe_pkg::OP_ST_W: return 4;
            default: return 0;
        endcase
    endfunction

    // predict the outcome and apply aligned stores to the memory model
    task automatic predict_outcome(input mem_pipe_pkg::issue_t ins, output expect_t e);
        mem_pipe_pkg::word_t addr;
        mem_pipe_pkg::word_t raw;
        int                  size;
        int                  row;
        int                  lane;
        addr    = ins.base + ins.offset;
        size    = access_size(ins.op);
        row     = (addr >> 2) % (1 << mem_pipe_pkg::SRAM_DEPTH_LOG2);
        lane    = addr % 4;
        raw     = '0;
        e.idx   = 16'(accepted);
        e.pc    = ins.pc;
        e.rd    = ins.rd;
        e.kind  = K_WRITE;
        e.value = addr;
        if (size > 1 && lane % size != 0) begin
            e.kind = K_EXC;
        end else if (ins.op inside {mem_pipe_pkg::OP_ST_B, mem_pipe_pkg::OP_ST_H,
                                    mem_pipe_pkg::OP_ST_W}) begin
            e.kind = K_STORE;
            for (int j = 0; j < size; j++) begin
                model_mem[row][8*(lane+j) +: 8] = ins.st_data[8*j +: 8];
            end
        end else if (size != 0) begin
            for (int j = 0; j < size; j++) begin
                raw[8*j +: 8] = model_mem[row][8*(lane+j) +: 8];
            end
            case (ins.op)
                mem_pipe_pkg::OP_LD_B: e.value = {{24{raw[7]}}, raw[7:0]};
                mem_pipe_pkg::OP_LD_H: e.value = {{16{raw[15]}}, raw[15:0]};
                default:               e.value = raw;
            endcase
        end
    endtask

    task automatic check_word(input string name, input mem_pipe_pkg::word_t got,
                              input mem_pipe_pkg::word_t want, input int idx,
                              inout logic ok);
        if (got !== want) begin
            $display("MISMATCH test %0d %s: got %h, expected %h", idx, name, got, want);
            ok = 1'b0;
        end
    endtask

    task automatic resolve_event();
        expect_t head;
        expect_t dropped;
        logic    ok;
        ok = 1'b1;
        // stores retire without anything visible at the ports
        while (pending_q.size() > 0 && pending_q[0].kind == K_STORE) begin
            head = pending_q.pop_front();
            $display("test %0d: store retired", head.idx);
            pass_count++;
        end
        if (pending_q.size() == 0) begin
            $display("ERROR: write or exception reported with no instruction outstanding");
            fail_count++;
        end else begin
            head = pending_q.pop_front();
            if (head.kind == K_WRITE && !rf_wr.we) begin
                $display("test %0d: expected a register write, got an exception", head.idx);
                ok = 1'b0;
            end else if (head.kind == K_WRITE) begin
                check_word("rf_wr.waddr", 32'(rf_wr.waddr), 32'(head.rd), head.idx, ok);
                check_word("rf_wr.wdata", rf_wr.wdata, head.value, head.idx, ok);
            end else if (!exc.valid) begin
                $display("test %0d: expected an exception, got a register write", head.idx);
                ok = 1'b0;
            end else begin
                check_word("exc.pc", exc.pc, head.pc, head.idx, ok);
                check_word("exc.code", 32'(exc.code), 32'(mem_pipe_pkg::EXC_ALE), head.idx, ok);
                check_word("exc.badv", exc.badv, head.value, head.idx, ok);
                // the rest of the queue is younger and got flushed
                while (pending_q.size() > 0) begin
                    dropped = pending_q.pop_front();
                    $display("test %0d: flushed", dropped.idx);
                    pass_count++;
                end
            end
            $display("test %0d: %s", head.idx, ok ? "ok" : "failed");
            if (ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
        end
    endtask

    always @(posedge clk) begin : monitor
        expect_t e;
        if (resetn) begin
            if (rf_wr.we || exc.valid) begin
                resolve_event();
            end
            if (in_valid && in_allowin) begin
                predict_outcome(in_instr, e);
                pending_q.push_back(e);
                accepted++;
            end
        end
        outstanding = pending_q.size();
    end

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk
);

    // period 8
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

// File: tb/tb_mem_pipe.sv
module tb_mem_pipe;

    typedef struct packed {
        mem_pipe_pkg::mem_op_e   op;
        mem_pipe_pkg::word_t     base;
        mem_pipe_pkg::word_t     offset;
        mem_pipe_pkg::word_t     st_data;
        mem_pipe_pkg::reg_addr_t rd;
        logic                    stall;
    } step_t;

    logic                      clk;
    logic                      resetn;
    logic                      in_valid;
    mem_pipe_pkg::issue_t      in_instr;
    logic                      retire_ready;
    logic                      in_allowin;
    mem_pipe_pkg::rf_write_t   rf_wr;
    mem_pipe_pkg::exc_report_t exc;
    int                        pass_count;
    int                        fail_count;
    int                        outstanding;

    step_t steps[$];
    int    seed = 71376;
    int    rnd;
    int    cycles = 0;
    int    cycle_limit = 0;
    logic  took;

    tb_clock_gen u_clock_gen (.clk(clk));

    mem_pipe_top UUT (.*);

    tb_checker u_checker (.*);

    task automatic add_step(input mem_pipe_pkg::mem_op_e op, input logic [31:0] base,
                            input logic [31:0] offset, input logic [31:0] data,
                            input logic [4:0] rd, input logic stall);
        steps.push_back('{op: op, base: base, offset: offset, st_data: data, rd: rd,
                          stall: stall});
    endtask

    task automatic build_table();
        add_step(mem_pipe_pkg::OP_ALU,   32'h0000_0010, 32'h5, 32'h0, 5'd1, 1'b0);
        add_step(mem_pipe_pkg::OP_ALU,   32'h7fff_ffff, 32'h1, 32'h0, 5'd2, 1'b0);
        // word store, then loads of each width
        add_step(mem_pipe_pkg::OP_ST_W,  32'h0000_0100, 32'h0, 32'h80f4_7f12, 5'd0, 1'b0);
        add_step(mem_pipe_pkg::OP_LD_W,  32'h0000_0100, 32'h0, 32'h0, 5'd3, 1'b0);
        add_step(mem_pipe_pkg::OP_LD_B,  32'h0000_00f0, 32'h11, 32'h0, 5'd4, 1'b0);
        add_step(mem_pipe_pkg::OP_LD_B,  32'h0000_0100, 32'h2, 32'h0, 5'd5, 1'b0);
        add_step(mem_pipe_pkg::OP_LD_BU, 32'h0000_0100, 32'h3, 32'h0, 5'd6, 1'b0);
        add_step(mem_pipe_pkg::OP_LD_H,  32'h0000_0100, 32'h2, 32'h0, 5'd7, 1'b0);
        add_step(mem_pipe_pkg::OP_LD_HU, 32'h0000_0100, 32'h2, 32'h0, 5'd8, 1'b0);
        // mixed lanes in one word under retire stalls
        add_step(mem_pipe_pkg::OP_ST_W,  32'h0000_0104, 32'h0, 32'h0, 5'd0, 1'b1);
        add_step(mem_pipe_pkg::OP_ST_B,  32'h0000_0104, 32'h1, 32'h0000_00ab, 5'd0, 1'b1);
        add_step(mem_pipe_pkg::OP_ST_H,  32'h0000_0110, 32'hffff_fff6, 32'h1234_c3d2, 5'd0, 1'b1);
        add_step(mem_pipe_pkg::OP_LD_W,  32'h0000_0104, 32'h0, 32'h0, 5'd9, 1'b1);
        add_step(mem_pipe_pkg::OP_LD_B,  32'h0000_0104, 32'h1, 32'h0, 5'd10, 1'b1);
        // each fault is followed by two fillers that the flush may drop
        add_step(mem_pipe_pkg::OP_LD_H,  32'h0000_0100, 32'h1, 32'h0, 5'd11, 1'b1);
        add_step(mem_pipe_pkg::OP_ALU,   32'h0000_0001, 32'h1, 32'h0, 5'd12, 1'b1);
        add_step(mem_pipe_pkg::OP_ALU,   32'h0000_0002, 32'h2, 32'h0, 5'd13, 1'b1);
        add_step(mem_pipe_pkg::OP_ST_W,  32'h0000_0100, 32'h2, 32'hdead_beef, 5'd0, 1'b0);
        add_step(mem_pipe_pkg::OP_ALU,   32'h0000_0003, 32'h3, 32'h0, 5'd14, 1'b0);
        add_step(mem_pipe_pkg::OP_ALU,   32'h0000_0004, 32'h4, 32'h0, 5'd15, 1'b0);
        add_step(mem_pipe_pkg::OP_LD_W,  32'h0000_0100, 32'h0, 32'h0, 5'd16, 1'b1);
        add_step(mem_pipe_pkg::OP_ST_H,  32'h0000_0100, 32'h3, 32'h0000_5555, 5'd0, 1'b1);
        add_step(mem_pipe_pkg::OP_ALU,   32'h0000_0005, 32'h5, 32'h0, 5'd17, 1'b1);
        add_step(mem_pipe_pkg::OP_ALU,   32'h0000_0006, 32'h6, 32'h0, 5'd18, 1'b1);
        add_step(mem_pipe_pkg::OP_LD_HU, 32'h0000_0100, 32'h2, 32'h0, 5'd19, 1'b1);
        add_step(mem_pipe_pkg::OP_ALU,   32'h0000_0020, 32'h22, 32'h0, 5'd20, 1'b0);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: pipeline did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        resetn       = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        retire_ready = 1'b1;
        build_table();
        cycle_limit = 20 * steps.size() + 50;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        // no retirement may appear in this idle window
        repeat (3) @(posedge clk);
        #1;
        foreach (steps[i]) begin
            in_valid = 1'b1;
            in_instr = '{pc: 32'h0000_1000 + 32'(4 * i), op: steps[i].op,
                         base: steps[i].base, offset: steps[i].offset,
                         st_data: steps[i].st_data, rd: steps[i].rd};
            // hold the entry until the pipeline takes it
            do begin
                rnd          = $random(seed);
                retire_ready = steps[i].stall ? rnd[0] : 1'b1;
                @(posedge clk);
                took = in_allowin;
                #1;
            end while (!took);
        end
        in_valid     = 1'b0;
        retire_ready = 1'b1;
        while (outstanding != 0) begin
            @(posedge clk);
            #1;
        end
        $display("%0d passed, %0d failed, %0d assertion failures", pass_count, fail_count,
                 UUT.u_assertions.violations);
        if (fail_count == 0 && pass_count == steps.size() &&
            UUT.u_assertions.violations == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
